//--- rtl/dual_port_ram_array.sv
// true dual-port byte-lane memory; registered read-first outputs, port a wins lane collisions
`timescale 1ns/1ps

module dual_port_ram_array (
    input  logic                    clk,

    // port a
    input  logic                    a_we_i,
    input  ram_geom_pkg::wb_sel_t   a_lane_i,
    input  ram_geom_pkg::ram_addr_t a_addr_i,
    input  ram_geom_pkg::wb_data_t  a_dat_i,
    output ram_geom_pkg::wb_data_t  a_dat_o,

    // port b
    input  logic                    b_we_i,
    input  ram_geom_pkg::wb_sel_t   b_lane_i,
    input  ram_geom_pkg::ram_addr_t b_addr_i,
    input  ram_geom_pkg::wb_data_t  b_dat_i,
    output ram_geom_pkg::wb_data_t  b_dat_o
);

    import ram_geom_pkg::*;

    wb_data_t mem [RAM_DEPTH];   // contents unknown until written

    wb_sel_t  a_wr_lane;   // lanes port a writes this edge
    wb_sel_t  b_wr_lane;   // lanes port b writes after the collision rule
    logic     same_addr;
    wb_data_t a_rd_q;
    wb_data_t b_rd_q;

    assign same_addr = (a_addr_i == b_addr_i);
    assign a_wr_lane = a_lane_i & {RAM_LANES{a_we_i}};

    // b loses any lane that a writes at the same address
    always_comb begin
        b_wr_lane = b_lane_i & {RAM_LANES{b_we_i}};
        if (same_addr) begin
            b_wr_lane = b_wr_lane & ~a_wr_lane;
        end
    end

    // the lane masks never overlap on one address, so write order does not matter
    always_ff @(posedge clk) begin
        for (int l = 0; l < RAM_LANES; l++) begin
            if (a_wr_lane[l]) begin
                mem[a_addr_i][l*RAM_LANE_W +: RAM_LANE_W] <= a_dat_i[l*RAM_LANE_W +: RAM_LANE_W];
            end
            if (b_wr_lane[l]) begin
                mem[b_addr_i][l*RAM_LANE_W +: RAM_LANE_W] <= b_dat_i[l*RAM_LANE_W +: RAM_LANE_W];
            end
        end
    end

    // read ports, sampled at the same edge as the write
    // so a read during a write to the same word returns the old word
    always_ff @(posedge clk) begin
        a_rd_q <= mem[a_addr_i];
        b_rd_q <= mem[b_addr_i];
    end

    assign a_dat_o = a_rd_q;   // valid one cycle after the address
    assign b_dat_o = b_rd_q;

endmodule

//--- rtl/ram_geom_pkg.sv
// geometry of the shared memory: word, address and lane types used by RTL and testbench
package ram_geom_pkg;

    localparam int RAM_DW     = 32;        // bus word width
    localparam int RAM_AW     = 10;        // word address width
    localparam int RAM_DEPTH  = 1024;      // words in the array
    localparam int RAM_LANES  = 4;         // byte lanes per word

    // width of one byte lane
    localparam int RAM_LANE_W = RAM_DW / RAM_LANES;

    // one bus data word
    typedef logic [RAM_DW-1:0] wb_data_t;

    // word address into the array
    typedef logic [RAM_AW-1:0] ram_addr_t;

    // byte lane select, bit i covers bits 8i+7..8i of wb_data_t
    typedef logic [RAM_LANES-1:0] wb_sel_t;

endpackage

//--- rtl/wb_bus_pkg.sv
// wishbone bus-side definitions shared by the slave ports, the top level and the testbench
package wb_bus_pkg;

    // cycle type identifier carried on cti

    typedef logic [2:0] wb_cti_t;

    // single transfer, the slave answers with an alternating ack
    localparam wb_cti_t CTI_CLASSIC     = 3'b000;

    // burst to one fixed address
    localparam wb_cti_t CTI_CONST_BURST = 3'b001;

    // burst with the address stepping by one word per beat
    localparam wb_cti_t CTI_INCR_BURST  = 3'b010;

    // reserved code in wb4, taken by the network interface
    // the master registers the ack on its side, so the slave
    // answers combinationally from stb
    localparam wb_cti_t CTI_NI_BURST    = 3'b100;

    // last beat of a burst
    localparam wb_cti_t CTI_END_BURST   = 3'b111;

    // codes 011, 101 and 110 are reserved as well
    // the slave ports answer those like classic cycles

endpackage

//--- rtl/wb_dual_port_ram.sv
// shared dual-port RAM with two wishbone slave ports, e.g. processor on a and NI on b
`timescale 1ns/1ps

module wb_dual_port_ram (
    input  logic                    clk,
    input  logic                    reset,

    // slave port a
    input  ram_geom_pkg::wb_data_t  sa_dat_i,
    input  ram_geom_pkg::wb_sel_t   sa_sel_i,
    input  ram_geom_pkg::ram_addr_t sa_addr_i,
    input  wb_bus_pkg::wb_cti_t     sa_cti_i,
    input  logic                    sa_stb_i,
    input  logic                    sa_cyc_i,
    input  logic                    sa_we_i,
    output ram_geom_pkg::wb_data_t  sa_dat_o,
    output logic                    sa_ack_o,

    // slave port b
    input  ram_geom_pkg::wb_data_t  sb_dat_i,
    input  ram_geom_pkg::wb_sel_t   sb_sel_i,
    input  ram_geom_pkg::ram_addr_t sb_addr_i,
    input  wb_bus_pkg::wb_cti_t     sb_cti_i,
    input  logic                    sb_stb_i,
    input  logic                    sb_cyc_i,
    input  logic                    sb_we_i,
    output ram_geom_pkg::wb_data_t  sb_dat_o,
    output logic                    sb_ack_o
);

    import ram_geom_pkg::*;
    import wb_bus_pkg::*;

    // port a toward the array
    logic      a_mem_we;
    wb_sel_t   a_mem_lane;
    ram_addr_t a_mem_addr;
    wb_data_t  a_mem_dat;

    // port b toward the array
    logic      b_mem_we;
    wb_sel_t   b_mem_lane;
    ram_addr_t b_mem_addr;
    wb_data_t  b_mem_dat;

    wb_slave_port port_a (
        .clk        (clk),
        .reset      (reset),
        .bus_sel_i  (sa_sel_i),
        .bus_addr_i (sa_addr_i),
        .bus_dat_i  (sa_dat_i),
        .bus_cti_i  (sa_cti_i),
        .bus_stb_i  (sa_stb_i),
        .bus_cyc_i  (sa_cyc_i),
        .bus_we_i   (sa_we_i),
        .bus_ack_o  (sa_ack_o),
        .mem_we_o   (a_mem_we),
        .mem_lane_o (a_mem_lane),
        .mem_addr_o (a_mem_addr),
        .mem_dat_o  (a_mem_dat)
    );

    wb_slave_port port_b (
        .clk        (clk),
        .reset      (reset),
        .bus_sel_i  (sb_sel_i),
        .bus_addr_i (sb_addr_i),
        .bus_dat_i  (sb_dat_i),
        .bus_cti_i  (sb_cti_i),
        .bus_stb_i  (sb_stb_i),
        .bus_cyc_i  (sb_cyc_i),
        .bus_we_i   (sb_we_i),
        .bus_ack_o  (sb_ack_o),
        .mem_we_o   (b_mem_we),
        .mem_lane_o (b_mem_lane),
        .mem_addr_o (b_mem_addr),
        .mem_dat_o  (b_mem_dat)
    );

    // read data goes straight back to the bus, no extra stage
    dual_port_ram_array ram_array (
        .clk      (clk),
        .a_we_i   (a_mem_we),
        .a_lane_i (a_mem_lane),
        .a_addr_i (a_mem_addr),
        .a_dat_i  (a_mem_dat),
        .a_dat_o  (sa_dat_o),
        .b_we_i   (b_mem_we),
        .b_lane_i (b_mem_lane),
        .b_addr_i (b_mem_addr),
        .b_dat_i  (b_mem_dat),
        .b_dat_o  (sb_dat_o)
    );

endmodule

//--- rtl/wb_slave_port.sv
// wishbone slave port: builds the ack from the cycle type and turns bus writes into lane writes
`timescale 1ns/1ps

module wb_slave_port (
    input  logic                    clk,
    input  logic                    reset,

    // wishbone slave side
    input  ram_geom_pkg::wb_sel_t   bus_sel_i,
    input  ram_geom_pkg::ram_addr_t bus_addr_i,
    input  ram_geom_pkg::wb_data_t  bus_dat_i,
    input  wb_bus_pkg::wb_cti_t     bus_cti_i,
    input  logic                    bus_stb_i,
    input  logic                    bus_cyc_i,
    input  logic                    bus_we_i,
    output logic                    bus_ack_o,

    // toward the memory array
    output logic                    mem_we_o,
    output ram_geom_pkg::wb_sel_t   mem_lane_o,
    output ram_geom_pkg::ram_addr_t mem_addr_o,
    output ram_geom_pkg::wb_data_t  mem_dat_o
);

    import ram_geom_pkg::*;
    import wb_bus_pkg::*;

    logic bus_req;   // valid request this cycle
    logic ni_mode;   // network interface cycle type
    logic ack_q;     // registered ack
    logic ack_d;

    assign bus_req = bus_stb_i & bus_cyc_i;
    assign ni_mode = (bus_cti_i == CTI_NI_BURST);

    // next value of the registered ack
    always_comb begin
        case (bus_cti_i)
            CTI_CLASSIC: begin
                ack_d = bus_req & ~ack_q;   // one on, one off
            end
            CTI_CONST_BURST,
            CTI_INCR_BURST,
            CTI_END_BURST: begin
                ack_d = bus_req;            // every beat after the first cycle
            end
            CTI_NI_BURST: begin
                ack_d = 1'b0;               // ack comes straight from stb instead
            end
            default: begin
                // reserved codes behave like classic
                ack_d = bus_req & ~ack_q;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= ack_d;
        end
    end

    // the interface master registers ack itself, so it gets stb back directly
    assign bus_ack_o = ni_mode ? bus_req : ack_q;

    // write qualification
    // a write lands on every edge where the request is present with we,
    // repeated edges of a held classic write store the same word again
    assign mem_we_o   = bus_req & bus_we_i;
    assign mem_lane_o = bus_sel_i & {RAM_LANES{mem_we_o}};   // only real write lanes

    assign mem_addr_o = bus_addr_i;
    assign mem_dat_o  = bus_dat_i;   // lanes not selected are ignored by the array

endmodule

//--- run_sim.sh
#!/bin/sh
# builds the testbench with verilator, runs it and checks the log for the pass message
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_wb_dual_port_ram \
    --Mdir obj_dir \
    -o tb_sim \
    -f tb.f

./obj_dir/tb_sim | tee sim.log

if grep -qx "TEST OK" sim.log; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed, see sim.log"
exit 1

//--- tb.f
rtl/ram_geom_pkg.sv
rtl/wb_bus_pkg.sv
rtl/wb_slave_port.sv
rtl/dual_port_ram_array.sv
rtl/wb_dual_port_ram.sv
verification/tb_wb_dual_port_ram.sv

//--- verification/ram_vectors.txt
# test port(0=a 1=b) op(0=rd 1=wr 2=wr with next line 3=burst rd beat) cti addr data sel expect
# test, port and op are decimal, the rest hex; expect is the read word and unused on writes
1 0 1 0 010 11223344 f 00000000
1 0 0 0 010 00000000 f 11223344
1 0 1 0 010 aabbccdd 3 00000000
1 0 0 0 010 00000000 f 1122ccdd
1 0 1 0 010 55667788 8 00000000
1 0 0 0 010 00000000 f 5522ccdd
2 1 1 0 020 cafef00d f 00000000
2 1 1 0 020 00001200 2 00000000
2 1 0 0 020 00000000 f cafe120d
2 0 1 0 021 01234567 f 00000000
2 1 0 0 021 00000000 f 01234567
2 1 1 0 022 89abcdef f 00000000
2 0 0 0 022 00000000 f 89abcdef
2 0 0 0 020 00000000 f cafe120d
3 0 1 0 030 a0a0a0a0 f 00000000
3 0 1 0 031 b1b1b1b1 f 00000000
3 0 1 0 032 c2c2c2c2 f 00000000
3 0 3 2 030 00000000 f a0a0a0a0
3 0 3 2 031 00000000 f b1b1b1b1
3 0 3 7 032 00000000 f c2c2c2c2
4 1 1 4 040 0badcafe f 00000000
4 1 1 4 040 0000ff00 2 00000000
4 1 0 4 040 00000000 f 0badfffe
4 0 0 4 040 00000000 f 0badfffe
4 0 1 4 041 13579bdf f 00000000
4 1 0 0 041 00000000 f 13579bdf
5 0 1 0 050 00000000 f 00000000
5 0 2 0 050 a1a2a3a4 3 00000000
5 1 1 0 050 b1b2b3b4 6 00000000
5 0 0 0 050 00000000 f 00b2a3a4
5 1 0 0 050 00000000 f 00b2a3a4
5 1 1 0 051 ffffffff f 00000000
5 0 2 0 051 11000000 8 00000000
5 1 1 0 051 00000022 1 00000000
5 1 0 0 051 00000000 f 11ffff22

//--- verification/tb_wb_dual_port_ram.sv
// self-checking testbench for the dual-port wishbone RAM, run from verification/ram_vectors.txt
`timescale 1ns/1ps

module tb_wb_dual_port_ram;

    import ram_geom_pkg::*;
    import wb_bus_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int SAMPLE_DLY = CLK_PERIOD / 4;   // after the falling edge, before the rising one
    localparam int ACK_LIMIT  = 4;                // cycles allowed for an ack
    localparam int OP_WRITE   = 1;
    localparam int OP_PAIR    = 2;   // write launched in the same cycle as the next line
    localparam int OP_BURST   = 3;   // read beat of a burst with stb held

    logic      clk;
    logic      reset;
    wb_data_t  sa_dat_i;
    wb_sel_t   sa_sel_i;
    ram_addr_t sa_addr_i;
    wb_cti_t   sa_cti_i;
    logic      sa_stb_i;
    logic      sa_cyc_i;
    logic      sa_we_i;
    wb_data_t  sa_dat_o;
    logic      sa_ack_o;
    wb_data_t  sb_dat_i;
    wb_sel_t   sb_sel_i;
    ram_addr_t sb_addr_i;
    wb_cti_t   sb_cti_i;
    logic      sb_stb_i;
    logic      sb_cyc_i;
    logic      sb_we_i;
    wb_data_t  sb_dat_o;
    logic      sb_ack_o;

    // one entry per vector line
    int        v_test[$];
    int        v_port[$];
    int        v_op[$];
    wb_cti_t   v_cti[$];
    ram_addr_t v_addr[$];
    wb_data_t  v_dat[$];
    wb_sel_t   v_sel[$];
    wb_data_t  v_exp[$];

    int n_lines = 0;
    int test_errs;
    int n_pass;
    int n_fail;

    wb_dual_port_ram wb_dual_port_ram_i (
        .clk       (clk),
        .reset     (reset),
        .sa_dat_i  (sa_dat_i),
        .sa_sel_i  (sa_sel_i),
        .sa_addr_i (sa_addr_i),
        .sa_cti_i  (sa_cti_i),
        .sa_stb_i  (sa_stb_i),
        .sa_cyc_i  (sa_cyc_i),
        .sa_we_i   (sa_we_i),
        .sa_dat_o  (sa_dat_o),
        .sa_ack_o  (sa_ack_o),
        .sb_dat_i  (sb_dat_i),
        .sb_sel_i  (sb_sel_i),
        .sb_addr_i (sb_addr_i),
        .sb_cti_i  (sb_cti_i),
        .sb_stb_i  (sb_stb_i),
        .sb_cyc_i  (sb_cyc_i),
        .sb_we_i   (sb_we_i),
        .sb_dat_o  (sb_dat_o),
        .sb_ack_o  (sb_ack_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic ack_of(int port);
        return (port == 0) ? sa_ack_o : sb_ack_o;
    endfunction

    function automatic wb_data_t dat_of(int port);
        return (port == 0) ? sa_dat_o : sb_dat_o;
    endfunction

    function automatic string ack_name(int port);
        return (port == 0) ? "sa_ack_o" : "sb_ack_o";
    endfunction

    function automatic string dat_name(int port);
        return (port == 0) ? "sa_dat_o" : "sb_dat_o";
    endfunction

    task automatic check_value(string name, logic [31:0] expv, logic [31:0] actv);
        assert (actv === expv) else begin
            $display("[FAIL] %0t ns %s expected %h actual %h", $time, name, expv, actv);
            test_errs++;
        end
    endtask

    task automatic drive_port(int port, logic stb, logic we, wb_cti_t cti, ram_addr_t addr,
                              wb_data_t dat, wb_sel_t sel);
        if (port == 0) begin
            sa_stb_i  = stb;
            sa_cyc_i  = stb;
            sa_we_i   = we;
            sa_cti_i  = cti;
            sa_addr_i = addr;
            sa_dat_i  = dat;
            sa_sel_i  = sel;
        end else begin
            sb_stb_i  = stb;
            sb_cyc_i  = stb;
            sb_we_i   = we;
            sb_cti_i  = cti;
            sb_addr_i = addr;
            sb_dat_i  = dat;
            sb_sel_i  = sel;
        end
    endtask

    task automatic drive_idle(int port);
        drive_port(port, 1'b0, 1'b0, CTI_CLASSIC, '0, '0, '0);
    endtask

    task automatic load_vectors(output bit ok);
        int         fd;
        int         n;
        string      line;
        int         t;
        int         p;
        int         o;
        logic [2:0]  c;
        logic [9:0]  a;
        logic [31:0] d;
        logic [3:0]  s;
        logic [31:0] e;
        ok = 1'b0;
        fd = $fopen("verification/ram_vectors.txt", "r");
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin   // skip blanks and comments
                    n = $sscanf(line, "%d %d %d %h %h %h %h %h", t, p, o, c, a, d, s, e);
                    if (n == 8) begin
                        v_test.push_back(t);
                        v_port.push_back(p);
                        v_op.push_back(o);
                        v_cti.push_back(c);
                        v_addr.push_back(a);
                        v_dat.push_back(d);
                        v_sel.push_back(s);
                        v_exp.push_back(e);
                    end
                end
            end
            $fclose(fd);
            n_lines = v_test.size();
            ok = (n_lines > 0);
        end
    endtask

    // single classic or NI transfer, stb held until ack
    task automatic run_single(int i);
        int   port;
        int   lat;
        bit   is_ni;
        logic we;
        port  = v_port[i];
        is_ni = (v_cti[i] == CTI_NI_BURST);
        we    = (v_op[i] == OP_WRITE);
        lat   = 0;
        @(negedge clk);
        drive_port(port, 1'b1, we, v_cti[i], v_addr[i], v_dat[i], v_sel[i]);
        #(SAMPLE_DLY);
        while (ack_of(port) !== 1'b1 && lat < ACK_LIMIT) begin
            @(negedge clk);
            #(SAMPLE_DLY);
            lat++;
        end
        assert (ack_of(port) === 1'b1) else begin
            $display("%0t ns: port %0d never acknowledged vector line %0d", $time, port, i);
            test_errs++;
        end
        if (ack_of(port) === 1'b1) begin
            check_value({ack_name(port), " delay"}, is_ni ? 32'd0 : 32'd1, lat);
            if (!we && !is_ni) begin
                check_value(dat_name(port), v_exp[i], dat_of(port));
            end
        end
        @(negedge clk);
        drive_idle(port);
        #(SAMPLE_DLY);
        check_value(ack_name(port), 32'd0, 32'(ack_of(port)));   // off cycle after the ack
        if (!we && is_ni) begin
            check_value(dat_name(port), v_exp[i], dat_of(port));  // NI data one cycle late
        end
    endtask

    // lines i and i+1 write in the same cycle on both ports
    task automatic run_pair(int i);
        @(negedge clk);
        for (int k = i; k <= i + 1; k++) begin
            drive_port(v_port[k], 1'b1, 1'b1, v_cti[k], v_addr[k], v_dat[k], v_sel[k]);
        end
        #(SAMPLE_DLY);
        for (int k = i; k <= i + 1; k++) begin
            check_value(ack_name(v_port[k]), 32'd0, 32'(ack_of(v_port[k])));
        end
        @(negedge clk);
        #(SAMPLE_DLY);
        for (int k = i; k <= i + 1; k++) begin
            check_value(ack_name(v_port[k]), 32'd1, 32'(ack_of(v_port[k])));
        end
        @(negedge clk);
        drive_idle(v_port[i]);
        drive_idle(v_port[i + 1]);
        #(SAMPLE_DLY);
        for (int k = i; k <= i + 1; k++) begin
            check_value(ack_name(v_port[k]), 32'd0, 32'(ack_of(v_port[k])));
        end
    endtask

    // beats first..last back to back, then one cycle to collect the last word
    task automatic run_burst(int first, int last);
        int port;
        port = v_port[first];
        for (int k = first; k <= last + 1; k++) begin
            @(negedge clk);
            if (k <= last) begin
                drive_port(port, 1'b1, 1'b0, v_cti[k], v_addr[k], '0, v_sel[k]);
            end else begin
                drive_idle(port);
            end
            #(SAMPLE_DLY);
            if (k == first) begin
                check_value(ack_name(port), 32'd0, 32'(ack_of(port)));
            end else begin
                check_value(ack_name(port), 32'd1, 32'(ack_of(port)));
                check_value(dat_name(port), v_exp[k - 1], dat_of(port));   // previous address
            end
        end
    endtask

    task automatic finish_test(int t);
        if (test_errs == 0) begin
            n_pass++;
            $display("test %0d passed", t);
        end else begin
            n_fail++;
            $display("test %0d failed with %0d errors", t, test_errs);
        end
        test_errs = 0;
    endtask

    initial begin : main_seq
        bit ok;
        int i;
        int last;
        int cur_test;
        clk       = 1'b0;
        reset     = 1'b1;
        n_pass    = 0;
        n_fail    = 0;
        test_errs = 0;
        drive_idle(0);
        drive_idle(1);
        void'($urandom(32'ha869_cf30));
        load_vectors(ok);
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        // test 0 covers the acks right after reset
        repeat (2) begin
            @(negedge clk);
            #(SAMPLE_DLY);
            check_value("sa_ack_o", 32'd0, 32'(sa_ack_o));
            check_value("sb_ack_o", 32'd0, 32'(sb_ack_o));
        end
        finish_test(0);
        if (!ok) begin
            $display("vector file missing or empty, no transfers were run");
            n_fail++;
        end else begin
            i = 0;
            cur_test = v_test[0];
            while (i < n_lines) begin
                if (v_test[i] != cur_test) begin
                    finish_test(cur_test);
                    cur_test = v_test[i];
                end
                if (v_op[i] == OP_BURST) begin
                    last = i;
                    while (last + 1 < n_lines && v_op[last + 1] == OP_BURST &&
                           v_cti[last] != CTI_END_BURST) begin
                        last++;
                    end
                    run_burst(i, last);
                    i = last + 1;
                end else if (v_op[i] == OP_PAIR && i + 1 < n_lines) begin
                    run_pair(i);
                    i += 2;
                end else begin
                    run_single(i);
                    i++;
                end
                repeat ($urandom % 4) @(negedge clk);   // idle gap
            end
            finish_test(cur_test);
        end
        $display("tests passed: %0d, tests failed: %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // ten cycles per vector line is far more than any transfer needs
    initial begin : watchdog
        wait (n_lines > 0);
        #((n_lines + 1) * 10 * CLK_PERIOD);
        $display("watchdog expired with %0d vector lines, run stopped", n_lines);
        $display("TEST FAILED");
        $finish;
    end

endmodule
